// ==== logic/lcd_pkg.sv ====
package lcd_pkg;

	localparam int INIT_LEN    = 12;
	localparam int INIT_LONG   = 4;    // leading init commands with long delay
	localparam int SHORT_DELAY = 5;
	localparam int LONG_DELAY  = 200;  // also each panel reset phase
	localparam int ROW_COUNT   = 3;
	localparam int ROW_CHARS   = 6;
	localparam int GLYPH_COLS  = 6;
	localparam int BLANK_COLS  = 2;
	localparam int CREDITS     = 2;    // serialiser queue depth

	localparam logic [7:0] PAGE_BASE  = 8'hB0;
	localparam logic [7:0] COL_HI_CMD = 8'h10;
	localparam logic [7:0] COL_LO_CMD = 8'h00;

	localparam int DELAY_W = $clog2(LONG_DELAY + 1);

	// last frame phase, csn rises at its end
	localparam logic [4:0] LAST_PHASE = 5'd16;

	// sequencer states
	localparam logic [2:0] SQ_WAIT   = 3'd0;
	localparam logic [2:0] SQ_RST_LO = 3'd1;
	localparam logic [2:0] SQ_RST_HI = 3'd2;
	localparam logic [2:0] SQ_INIT   = 3'd3;
	localparam logic [2:0] SQ_LOAD   = 3'd4;
	localparam logic [2:0] SQ_ADDR   = 3'd5;
	localparam logic [2:0] SQ_CHAR   = 3'd6;

	typedef logic [15:0] bcd4_t;      // four bcd digits, msd on top
	typedef logic [47:0] row_str_t;   // leftmost char in top byte

	typedef struct packed {
		logic       is_data;     // low for command
		logic       long_delay;
		logic [7:0] value;
	} lcd_byte_t;

	// one job word, read as a command byte or as a character code
	typedef union packed {
		lcd_byte_t cmd;
		struct packed {
			logic [1:0] pad;
			logic [7:0] code;
		} glyph;
	} lcd_job_u;

	typedef struct packed {
		logic     is_glyph;
		lcd_job_u body;
	} lcd_job_t;

endpackage

// ==== logic/lcd_sequencer.sv ====
module lcd_sequencer import lcd_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     idle,
	input  logic     job_ready,
	output lcd_job_t job,
	output logic     job_valid,
	output logic [1:0] row,
	output logic     load,
	input  row_str_t row_str,
	output logic     lcd_rst
);

	logic [2:0]         state;
	logic [3:0]         step;      // init index, address command or char index
	logic [DELAY_W-1:0] dly_cnt;

	function automatic logic [7:0] init_cmd(input logic [3:0] idx);
		case (idx)
			4'd0:    return 8'hE2;  // soft reset
			4'd1:    return 8'h2C;  // booster on
			4'd2:    return 8'h2E;  // regulator on
			4'd3:    return 8'h2F;  // follower on
			4'd4:    return 8'h23;
			4'd5:    return 8'h81;
			4'd6:    return 8'h28;
			4'd7:    return 8'hA2;  // bias 1/9
			4'd8:    return 8'hC8;  // com scan reversed
			4'd9:    return 8'hA0;
			4'd10:   return 8'h40;  // start line 0
			default: return 8'hAF;  // display on
		endcase
	endfunction

	always_comb begin
		job       = '0;
		job_valid = 1'b0;
		load      = (state == SQ_LOAD);
		case (state)
			SQ_INIT: begin
				job_valid                = 1'b1;
				job.body.cmd.long_delay  = (step < INIT_LONG);
				job.body.cmd.value       = init_cmd(step);
			end
			SQ_ADDR: begin
				job_valid = 1'b1;
				case (step)
					4'd0:    job.body.cmd.value = PAGE_BASE + {6'd0, row};
					4'd1:    job.body.cmd.value = COL_HI_CMD;
					default: job.body.cmd.value = COL_LO_CMD;
				endcase
			end
			SQ_CHAR: begin
				job_valid            = 1'b1;
				job.is_glyph         = 1'b1;
				job.body.glyph.code  = row_str[8 * (ROW_CHARS - 1 - step) +: 8];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= SQ_WAIT;
			step    <= '0;
			dly_cnt <= '0;
			row     <= '0;
			lcd_rst <= 1'b1;
		end else begin
			case (state)
				SQ_WAIT: if (idle) begin
					lcd_rst <= 1'b0;
					dly_cnt <= DELAY_W'(LONG_DELAY - 1);
					state   <= SQ_RST_LO;
				end
				SQ_RST_LO: begin
					if (dly_cnt != '0) begin
						dly_cnt <= dly_cnt - 1'b1;
					end else if (idle) begin
						lcd_rst <= 1'b1;
						dly_cnt <= DELAY_W'(LONG_DELAY - 1);
						state   <= SQ_RST_HI;
					end
				end
				SQ_RST_HI: begin
					if (dly_cnt != '0) dly_cnt <= dly_cnt - 1'b1;
					else state <= SQ_INIT;
				end
				SQ_INIT: if (job_ready) begin
					step <= step + 4'd1;
					if (step == 4'(INIT_LEN - 1)) begin
						step  <= '0;
						state <= SQ_LOAD;
					end
				end
				SQ_LOAD: state <= SQ_ADDR;  // row_str valid from next cycle
				SQ_ADDR: if (job_ready) begin
					step <= step + 4'd1;
					if (step == 4'd2) begin
						step  <= '0;
						state <= SQ_CHAR;
					end
				end
				SQ_CHAR: if (job_ready) begin
					step <= step + 4'd1;
					if (step == 4'(ROW_CHARS - 1)) begin
						step  <= '0;
						row   <= (row == 2'(ROW_COUNT - 1)) ? 2'd0 : row + 2'd1;
						state <= SQ_LOAD;
					end
				end
				default: state <= SQ_WAIT;
			endcase
		end
	end

endmodule

// ==== logic/field_formatter.sv ====
module field_formatter import lcd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  bcd4_t      tem,
	input  bcd4_t      hum,
	input  bcd4_t      vol,
	input  logic [1:0] row,
	input  logic       load,
	output row_str_t   row_str
);

	function automatic logic [7:0] to_ascii(input logic [3:0] digit);
		return {4'h3, digit};
	endfunction

	// temperature row, "dddd" then degree mark and C
	function automatic row_str_t fmt_tem(input bcd4_t v);
		return {to_ascii(v[15:12]), to_ascii(v[11:8]),
			to_ascii(v[7:4]), to_ascii(v[3:0]), "$C"};
	endfunction

	function automatic row_str_t fmt_hum(input bcd4_t v);
		return {to_ascii(v[15:12]), to_ascii(v[11:8]),
			to_ascii(v[7:4]), to_ascii(v[3:0]), "% "};
	endfunction

	// voltage has one integer digit
	function automatic row_str_t fmt_vol(input bcd4_t v);
		return {to_ascii(v[15:12]), ".", to_ascii(v[11:8]),
			to_ascii(v[7:4]), to_ascii(v[3:0]), "V"};
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_str <= {ROW_CHARS{8'h20}};  // blank row
		end else if (load) begin
			case (row)
				2'd0:    row_str <= fmt_tem(tem);
				2'd1:    row_str <= fmt_hum(hum);
				2'd2:    row_str <= fmt_vol(vol);
				default: row_str <= row_str;
			endcase
		end
	end

endmodule

// ==== logic/glyph_renderer.sv ====
module glyph_renderer import lcd_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  lcd_job_t  job,
	input  logic      job_valid,
	output logic      job_ready,
	output lcd_byte_t byte_out,
	output logic      byte_valid,
	input  logic      credit_return
);

	logic [1:0]  credit_cnt;
	logic        expanding;
	logic [2:0]  col_cnt;     // blank columns first, then font
	logic [47:0] glyph_bits;  // font columns still to send, leftmost on top
	logic        have_credit;
	logic        accept;
	logic        col_send;
	logic        spend;

	function automatic logic [47:0] font(input logic [7:0] code);
		case (code)
			"0":     return 48'h00_3E_51_49_45_3E;
			"1":     return 48'h00_00_42_7F_40_00;
			"2":     return 48'h00_42_61_51_49_46;
			"3":     return 48'h00_21_41_45_4B_31;
			"4":     return 48'h00_18_14_12_7F_10;
			"5":     return 48'h00_27_45_45_45_39;
			"6":     return 48'h00_3C_4A_49_49_30;
			"7":     return 48'h00_01_71_09_05_03;
			"8":     return 48'h00_36_49_49_49_36;
			"9":     return 48'h00_06_49_49_29_1E;
			".":     return 48'h00_00_60_60_00_00;
			"%":     return 48'h42_25_12_48_A4_42;
			"C":     return 48'h00_3E_41_41_41_22;
			"V":     return 48'h00_1F_20_40_20_1F;
			"$":     return 48'h00_06_09_09_06_00;  // degree mark
			default: return 48'h00_00_00_00_00_00;  // space and unknown codes
		endcase
	endfunction

	assign have_credit = (credit_cnt != 2'd0);
	assign job_ready   = have_credit && !expanding;
	assign accept      = job_valid && job_ready;
	assign col_send    = expanding && have_credit;
	assign spend       = accept || col_send;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credit_cnt <= 2'(CREDITS);
			expanding  <= 1'b0;
			col_cnt    <= '0;
			byte_valid <= 1'b0;
		end else begin
			credit_cnt <= credit_cnt - {1'b0, spend} + {1'b0, credit_return};
			byte_valid <= spend;
			if (accept) begin
				expanding <= job.is_glyph;
				col_cnt   <= 3'd1;  // column 0 goes out with the accept
			end else if (col_send) begin
				col_cnt <= col_cnt + 3'd1;
				if (col_cnt == 3'(BLANK_COLS + GLYPH_COLS - 1)) expanding <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			if (job.is_glyph) begin
				byte_out   <= '{is_data: 1'b1, long_delay: 1'b0, value: 8'h00};
				glyph_bits <= font(job.body.glyph.code);
			end else begin
				byte_out <= job.body.cmd;
			end
		end else if (col_send) begin
			byte_out.is_data    <= 1'b1;
			byte_out.long_delay <= 1'b0;
			if (col_cnt < BLANK_COLS) begin
				byte_out.value <= 8'h00;
			end else begin
				byte_out.value <= glyph_bits[47:40];
				glyph_bits     <= {glyph_bits[39:0], 8'h00};
			end
		end
	end

endmodule

// ==== logic/spi_serializer.sv ====
module spi_serializer import lcd_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  lcd_byte_t byte_in,
	input  logic      byte_valid,
	output logic      credit_return,
	output logic      idle,
	output logic      lcd_csn,
	output logic      lcd_dcn,
	output logic      lcd_clk,
	output logic      lcd_dat
);

	lcd_byte_t          q_mem [CREDITS];
	logic               q_wr;
	logic               q_rd;
	logic [1:0]         q_cnt;
	logic               active;    // frame on the wire
	logic [4:0]         phase;
	logic [DELAY_W-1:0] dly_cnt;
	logic [7:0]         shift;
	logic               cur_long;
	logic               pop;

	assign pop           = (q_cnt != 2'd0) && !active && (dly_cnt == '0);
	assign credit_return = pop;
	assign idle          = (q_cnt == 2'd0) && !active && (dly_cnt == '0);

	always_ff @(posedge clk) begin
		if (byte_valid) q_mem[q_wr] <= byte_in;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q_wr  <= 1'b0;
			q_rd  <= 1'b0;
			q_cnt <= '0;
		end else begin
			if (byte_valid) q_wr <= !q_wr;
			if (pop) q_rd <= !q_rd;
			q_cnt <= q_cnt + {1'b0, byte_valid} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active  <= 1'b0;
			phase   <= '0;
			dly_cnt <= '0;
			lcd_csn <= 1'b1;
			lcd_dcn <= 1'b0;
			lcd_clk <= 1'b1;
			lcd_dat <= 1'b0;
		end else if (pop) begin
			active  <= 1'b1;
			phase   <= '0;
			lcd_csn <= 1'b0;
			lcd_dcn <= q_mem[q_rd].is_data;  // held until the next pop
		end else if (active) begin
			phase <= phase + 5'd1;
			if (phase == LAST_PHASE) begin
				lcd_csn <= 1'b1;
				active  <= 1'b0;
				dly_cnt <= cur_long ? DELAY_W'(LONG_DELAY) : DELAY_W'(SHORT_DELAY);
			end else if (!phase[0]) begin
				lcd_clk <= 1'b0;
				lcd_dat <= shift[7];  // msb first
			end else begin
				lcd_clk <= 1'b1;
			end
		end else if (dly_cnt != '0) begin
			dly_cnt <= dly_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			shift    <= q_mem[q_rd].value;
			cur_long <= q_mem[q_rd].long_delay;
		end else if (active && !phase[0] && phase != LAST_PHASE) begin
			shift <= {shift[6:0], 1'b0};
		end
	end

endmodule

// ==== logic/lcd_top.sv ====
module lcd_top import lcd_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  bcd4_t tem,
	input  bcd4_t hum,
	input  bcd4_t vol,
	output logic  lcd_rst,
	output logic  lcd_csn,
	output logic  lcd_dcn,
	output logic  lcd_clk,
	output logic  lcd_dat
);

	lcd_job_t   job;
	logic       job_valid;
	logic       job_ready;
	logic [1:0] row;
	logic       load;
	row_str_t   row_str;
	lcd_byte_t  byte_out;
	logic       byte_valid;
	logic       credit_return;
	logic       idle;

	lcd_sequencer i_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.idle      (idle),
		.job_ready (job_ready),
		.job       (job),
		.job_valid (job_valid),
		.row       (row),
		.load      (load),
		.row_str   (row_str),
		.lcd_rst   (lcd_rst)
	);

	field_formatter i_formatter (
		.clk     (clk),
		.rst_n   (rst_n),
		.tem     (tem),
		.hum     (hum),
		.vol     (vol),
		.row     (row),
		.load    (load),
		.row_str (row_str)
	);

	glyph_renderer i_renderer (
		.clk           (clk),
		.rst_n         (rst_n),
		.job           (job),
		.job_valid     (job_valid),
		.job_ready     (job_ready),
		.byte_out      (byte_out),
		.byte_valid    (byte_valid),
		.credit_return (credit_return)
	);

	spi_serializer i_serializer (
		.clk           (clk),
		.rst_n         (rst_n),
		.byte_in       (byte_out),
		.byte_valid    (byte_valid),
		.credit_return (credit_return),
		.idle          (idle),
		.lcd_csn       (lcd_csn),
		.lcd_dcn       (lcd_dcn),
		.lcd_clk       (lcd_clk),
		.lcd_dat       (lcd_dat)
	);

endmodule

// ==== tests/lcd_tb_clk.sv ====
module lcd_tb_clk (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
	end

	always #2 clk = ~clk;  // 4 ns period

endmodule

// ==== tests/lcd_sva.sv ====
module lcd_sva import lcd_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input logic       pins_on,     // high where the serial pins are connected
	input logic       csn,
	input logic       dcn,
	input logic       sclk,
	input logic [1:0] credit_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	sclk_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		pins_on && !$stable(sclk) |-> !csn)
		else $error("lcd_clk moved while csn was high");

	dcn_held: assert property (@(posedge clk) disable iff (!rst_n)
		pins_on && !csn && !$fell(csn) |-> $stable(dcn))
		else $error("lcd_dcn changed inside a frame");

	sclk_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		pins_on && $rose(csn) |-> sclk)
		else $error("lcd_clk not high at frame end");

	credit_range: assert property (@(posedge clk) disable iff (!rst_n)
		credit_cnt <= 2'(CREDITS))
		else $error("credit or queue count above queue depth");

endmodule

bind spi_serializer lcd_sva i_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.pins_on    (1'b1),
	.csn        (lcd_csn),
	.dcn        (lcd_dcn),
	.sclk       (lcd_clk),
	.credit_cnt (q_cnt)
);

bind glyph_renderer lcd_sva i_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.pins_on    (1'b0),
	.csn        (1'b1),
	.dcn        (1'b0),
	.sclk       (1'b1),
	.credit_cnt (credit_cnt)
);

// ==== tests/lcd_tb.sv ====
module lcd_tb import lcd_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CHECK_ROWS = 6;  // two refresh rounds
	localparam int ROW_BYTES  = 3 + ROW_CHARS * (BLANK_COLS + GLYPH_COLS);
	localparam int FRAME_S    = 18 + SHORT_DELAY;
	localparam int FRAME_L    = 18 + LONG_DELAY;
	localparam int RUN_CYCLES = 8 + 2 * LONG_DELAY + INIT_LONG * FRAME_L
		+ (INIT_LEN - INIT_LONG) * FRAME_S + (CHECK_ROWS + 1) * ROW_BYTES * FRAME_S;
	localparam int LIMIT      = RUN_CYCLES * 5 / 4;

	localparam logic [7:0] INIT_TABLE [INIT_LEN] = '{
		8'hE2, 8'h2C, 8'h2E, 8'h2F, 8'h23, 8'h81,
		8'h28, 8'hA2, 8'hC8, 8'hA0, 8'h40, 8'hAF
	};

	logic      clk;
	logic      rst_n;
	bcd4_t     tem;
	bcd4_t     hum;
	bcd4_t     vol;
	logic      lcd_rst;
	logic      lcd_csn;
	logic      lcd_dcn;
	logic      lcd_clk;
	logic      lcd_dat;
	integer    seed = 32'hb9a9_f4d4;
	lcd_byte_t byte_q [$];
	row_str_t  str_q [$];
	int        rst_falls;
	logic      prev_rst;
	logic      prev_csn;
	logic      prev_sclk;
	logic [7:0] shreg;
	int        bit_cnt;
	int        gap_cnt;    // csn high samples since last frame
	lcd_byte_t pending;    // long_delay known only from the following gap
	logic      have_pending;
	logic      load_prev;

	lcd_tb_clk i_clk (
		.clk   (clk),
		.rst_n (rst_n)
	);

	lcd_top i_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.tem     (tem),
		.hum     (hum),
		.vol     (vol),
		.lcd_rst (lcd_rst),
		.lcd_csn (lcd_csn),
		.lcd_dcn (lcd_dcn),
		.lcd_clk (lcd_clk),
		.lcd_dat (lcd_dat)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_byte(input string name, input lcd_byte_t exp, input lcd_byte_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAIL %s expected dc=%b long=%b val=%h actual dc=%b long=%b val=%h",
				name, exp.is_data, exp.long_delay, exp.value,
				act.is_data, act.long_delay, act.value));
		end
	endtask

	task automatic compare_str(input string name, input row_str_t exp, input row_str_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
		end
	endtask

	function automatic bcd4_t rand_bcd();
		bcd4_t v;
		for (int i = 0; i < 4; i++) begin
			v[4*i +: 4] = 4'($unsigned($random(seed)) % 10);
		end
		return v;
	endfunction

	function automatic logic [7:0] digit_char(input logic [3:0] d);
		return 8'd48 + {4'd0, d};
	endfunction

	function automatic row_str_t row_ref(input int r, input bcd4_t t, input bcd4_t h,
		input bcd4_t v);
		row_str_t s;
		case (r)
			0: s = {digit_char(t[15:12]), digit_char(t[11:8]), digit_char(t[7:4]),
				digit_char(t[3:0]), 8'h24, 8'h43};
			1: s = {digit_char(h[15:12]), digit_char(h[11:8]), digit_char(h[7:4]),
				digit_char(h[3:0]), 8'h25, 8'h20};
			default: s = {digit_char(v[15:12]), 8'h2E, digit_char(v[11:8]),
				digit_char(v[7:4]), digit_char(v[3:0]), 8'h56};
		endcase
		return s;
	endfunction

	// font column col of a glyph, leftmost is 0
	function automatic logic [7:0] font_ref(input logic [7:0] code, input int col);
		logic [47:0] g;
		case (code)
			8'h30: g = 48'h00_3E_51_49_45_3E;
			8'h31: g = 48'h00_00_42_7F_40_00;
			8'h32: g = 48'h00_42_61_51_49_46;
			8'h33: g = 48'h00_21_41_45_4B_31;
			8'h34: g = 48'h00_18_14_12_7F_10;
			8'h35: g = 48'h00_27_45_45_45_39;
			8'h36: g = 48'h00_3C_4A_49_49_30;
			8'h37: g = 48'h00_01_71_09_05_03;
			8'h38: g = 48'h00_36_49_49_49_36;
			8'h39: g = 48'h00_06_49_49_29_1E;
			8'h2E: g = 48'h00_00_60_60_00_00;
			8'h25: g = 48'h42_25_12_48_A4_42;
			8'h43: g = 48'h00_3E_41_41_41_22;
			8'h56: g = 48'h00_1F_20_40_20_1F;
			8'h24: g = 48'h00_06_09_09_06_00;  // degree
			default: g = '0;
		endcase
		return g[8 * (GLYPH_COLS - 1 - col) +: 8];
	endfunction

	function automatic lcd_byte_t cmd_ref(input logic [7:0] value, input logic long_dly);
		return '{is_data: 1'b0, long_delay: long_dly, value: value};
	endfunction

	// new value always differs so a stale row shows up
	task automatic change_reading(input int r);
		bcd4_t nv;
		case (r)
			0: begin
				do nv = rand_bcd(); while (nv == tem);
				tem <= nv;
			end
			1: begin
				do nv = rand_bcd(); while (nv == hum);
				hum <= nv;
			end
			default: begin
				do nv = rand_bcd(); while (nv == vol);
				vol <= nv;
			end
		endcase
	endtask

	task automatic next_byte(output lcd_byte_t b);
		while (byte_q.size() == 0) @(posedge clk);
		b = byte_q.pop_front();
	endtask

	task automatic next_str(output row_str_t s);
		while (str_q.size() == 0) @(posedge clk);
		s = str_q.pop_front();
	endtask

	initial begin
		tem = rand_bcd();
		hum = rand_bcd();
		vol = rand_bcd();
	end

	// serial decoder
	always @(posedge clk) begin
		if (!rst_n) begin
			prev_rst     = 1'b1;
			prev_csn     = 1'b1;
			prev_sclk    = 1'b1;
			bit_cnt      = 0;
			gap_cnt      = 0;
			have_pending = 1'b0;
			rst_falls    = 0;
		end else begin
			if (prev_rst && !lcd_rst) rst_falls++;
			if (!lcd_rst && !lcd_csn) abort_run("a frame started while lcd_rst was low");
			if (prev_csn && !lcd_csn) begin
				if (have_pending) begin
					pending.long_delay = (gap_cnt >= LONG_DELAY);
					byte_q.push_back(pending);
				end
				bit_cnt = 0;
			end
			if (!lcd_csn && lcd_clk && !prev_sclk) begin
				shreg = {shreg[6:0], lcd_dat};  // msb first
				bit_cnt++;
			end
			if (!prev_csn && lcd_csn) begin
				if (bit_cnt != 8) begin
					abort_run($sformatf("a frame carried %0d lcd_clk edges, not 8", bit_cnt));
				end
				pending      = '{is_data: lcd_dcn, long_delay: 1'b0, value: shreg};
				have_pending = 1'b1;
				gap_cnt      = 0;
			end else if (lcd_csn) begin
				gap_cnt++;
			end
			prev_rst  = lcd_rst;
			prev_csn  = lcd_csn;
			prev_sclk = lcd_clk;
		end
	end

	// row string as latched by the formatter
	always @(posedge clk) begin
		if (!rst_n) begin
			load_prev = 1'b0;
		end else begin
			if (load_prev) str_q.push_back(i_dut.row_str);
			load_prev = i_dut.load;
		end
	end

	initial begin : compare_proc
		lcd_byte_t   got;
		row_str_t    exp_str;
		row_str_t    act_str;
		logic [7:0]  code;
		int          r;
		wait (rst_n === 1'b1);
		for (int i = 0; i < INIT_LEN; i++) begin
			next_byte(got);
			compare_byte($sformatf("init%0d", i), cmd_ref(INIT_TABLE[i], i < INIT_LONG), got);
		end
		for (int n = 0; n < CHECK_ROWS; n++) begin
			r = n % ROW_COUNT;
			next_byte(got);
			compare_byte($sformatf("row%0d page", n), cmd_ref(PAGE_BASE + 8'(r), 1'b0), got);
			exp_str = row_ref(r, tem, hum, vol);
			change_reading((r + 2) % ROW_COUNT);  // row before this one
			next_byte(got);
			compare_byte($sformatf("row%0d col_hi", n), cmd_ref(COL_HI_CMD, 1'b0), got);
			next_byte(got);
			compare_byte($sformatf("row%0d col_lo", n), cmd_ref(COL_LO_CMD, 1'b0), got);
			next_str(act_str);
			compare_str($sformatf("row%0d string", n), exp_str, act_str);
			for (int c = 0; c < ROW_CHARS; c++) begin
				code = exp_str[8 * (ROW_CHARS - 1 - c) +: 8];
				for (int k = 0; k < BLANK_COLS + GLYPH_COLS; k++) begin
					next_byte(got);
					compare_byte($sformatf("row%0d char%0d col%0d", n, c, k),
						'{is_data: 1'b1, long_delay: 1'b0,
						value: (k < BLANK_COLS) ? 8'h00 : font_ref(code, k - BLANK_COLS)},
						got);
				end
			end
		end
		if (rst_falls != 1 || lcd_rst !== 1'b1) begin
			abort_run($sformatf("lcd_rst fell %0d times or did not return high", rst_falls));
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

	initial begin : watchdog
		repeat (LIMIT) @(posedge clk);
		abort_run($sformatf("timeout, checks not done after %0d cycles", LIMIT));
	end

endmodule

// ==== lcd_top.f ====
logic/lcd_pkg.sv
logic/lcd_sequencer.sv
logic/field_formatter.sv
logic/glyph_renderer.sv
logic/spi_serializer.sv
logic/lcd_top.sv
tests/lcd_tb_clk.sv
tests/lcd_sva.sv
tests/lcd_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := lcd_tb
FILELIST   := lcd_top.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
